//--- hdl/pep9Pkg.sv
// Shared types for the 8-bit Pep/9 subset core
// Non-unary specifiers are always treated as immediate, so aaa bits are ignored
// Unary specifiers carry a zero upper nibble
`default_nettype none

package pep9Pkg;

    typedef logic [7:0]  byteT;    // Register, operand and memory data
    typedef logic [15:0] addrT;    // PC and bus address
    typedef logic        regSelT;  // 0 = A, 1 = X

    typedef struct packed {
        logic n;
        logic z;
        logic v;
        logic c;
    } flagsT;

    typedef enum logic [3:0] {
        opLoad,
        opAdd,
        opSub,    // Also used by CPB
        opAnd,
        opOr,
        opNot,
        opNeg,
        opAsl,
        opAsr,
        opRol
    } aluOpT;

    typedef struct packed {
        aluOpT  op;
        regSelT regSel;
        logic   writeBack;
        logic   active;    // Clear for a no-op
    } decodedT;

    typedef enum logic [1:0] {stFetch, stDecode, stExecute, stStore} cpuStateT;

    // Upper specifier nibble of the non-unary groups
    localparam logic [3:0] nuAdd = 4'd6;
    localparam logic [3:0] nuSub = 4'd7;
    localparam logic [3:0] nuAnd = 4'd8;
    localparam logic [3:0] nuOr  = 4'd9;
    localparam logic [3:0] nuCpb = 4'd11;
    localparam logic [3:0] nuLdb = 4'd13;

    // Unary opcode in specifier bits 3..1
    localparam logic [2:0] unNot = 3'd3;
    localparam logic [2:0] unNeg = 3'd4;
    localparam logic [2:0] unAsl = 3'd5;
    localparam logic [2:0] unAsr = 3'd6;
    localparam logic [2:0] unRol = 3'd7;

endpackage

`default_nettype wire

//--- hdl/pep9Sequencer.sv
// Instruction cycle FSM: fetch, decode, execute, store
// All outputs are registered and low during reset
`timescale 1ns/10ps
`default_nettype none

module pep9Sequencer import pep9Pkg::*; (
    input  wire logic Sysclk,
    input  wire logic resetbar,
    input  wire logic fetchDone,
    output logic      fetchStart,
    output logic      decodeEn,
    output logic      executeEn,
    output logic      storeEn,
    output logic      retire
);

    cpuStateT state;
    logic     bootStart;    // First fetch after reset release

    always_ff @(posedge Sysclk)
    begin
        if (!resetbar)
        begin
            state      <= stFetch;
            bootStart  <= 1'b1;
            fetchStart <= 1'b0;
            decodeEn   <= 1'b0;
            executeEn  <= 1'b0;
            storeEn    <= 1'b0;
            retire     <= 1'b0;
        end
        else
        begin
            bootStart  <= 1'b0;
            fetchStart <= bootStart || (state == stStore);   // Cycle after retire
            decodeEn   <= 1'b0;
            executeEn  <= 1'b0;
            storeEn    <= 1'b0;
            retire     <= 1'b0;
            case (state)
                stFetch:
                    if (fetchDone)
                    begin
                        state    <= stDecode;
                        decodeEn <= 1'b1;
                    end
                stDecode:
                begin
                    state     <= stExecute;
                    executeEn <= 1'b1;
                end
                stExecute:
                begin
                    state   <= stStore;
                    storeEn <= 1'b1;
                    retire  <= 1'b1;
                end
                default: state <= stFetch;   // stStore
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/pep9Fetch.sv
// Fetch unit and four-phase bus master
// Reads the specifier, then one operand byte when the upper nibble is nonzero
// fetchDone pulses the cycle after memAck is seen low for the last byte
`timescale 1ns/10ps
`default_nettype none

module pep9Fetch import pep9Pkg::*; #(
    parameter addrT resetPc = 16'h0000
) (
    input  wire logic Sysclk,
    input  wire logic resetbar,
    input  wire logic fetchStart,
    output logic      memReq,
    output addrT      memAddr,
    input  wire logic memAck,
    input  byteT      memData,
    output byteT      specifier,
    output byteT      operand,
    output logic      fetchDone
);

    typedef enum logic [2:0] {fsIdle, fsSpecReq, fsSpecRel, fsOperReq, fsOperRel} fetchStateT;

    fetchStateT fState;
    addrT       pc;

    // PC only moves after memReq drops, so the address holds during a request
    assign memAddr = pc;

    always_ff @(posedge Sysclk)
    begin
        if (!resetbar)
        begin
            fState    <= fsIdle;
            pc        <= resetPc;
            memReq    <= 1'b0;
            fetchDone <= 1'b0;
        end
        else
        begin
            fetchDone <= 1'b0;
            case (fState)
                fsIdle:
                    if (fetchStart)
                    begin
                        memReq <= 1'b1;
                        fState <= fsSpecReq;
                    end
                fsSpecReq:
                    if (memAck)
                    begin
                        memReq <= 1'b0;
                        pc     <= pc + 16'd1;
                        fState <= fsSpecRel;
                    end
                fsSpecRel:
                    if (!memAck)
                    begin
                        if (specifier[7:4] != 4'd0)   // Non-unary needs the operand
                        begin
                            memReq <= 1'b1;
                            fState <= fsOperReq;
                        end
                        else
                        begin
                            fetchDone <= 1'b1;
                            fState    <= fsIdle;
                        end
                    end
                fsOperReq:
                    if (memAck)
                    begin
                        memReq <= 1'b0;
                        pc     <= pc + 16'd1;
                        fState <= fsOperRel;
                    end
                fsOperRel:
                    if (!memAck)
                    begin
                        fetchDone <= 1'b1;
                        fState    <= fsIdle;
                    end
                default: fState <= fsIdle;
            endcase
        end
    end

    // Captured on the first acked cycle
    always_ff @(posedge Sysclk)
    begin
        if (fState == fsSpecReq && memAck)
            specifier <= memData;
        if (fState == fsOperReq && memAck)
            operand <= memData;
    end

endmodule

`default_nettype wire

//--- hdl/pep9Decode.sv
// Opcode decoder, registers control word and both ALU operands on decodeEn
// Unknown specifiers decode to a no-op with active clear
`timescale 1ns/10ps
`default_nettype none

module pep9Decode import pep9Pkg::*; (
    input  wire logic Sysclk,
    input  wire logic resetbar,
    input  wire logic decodeEn,
    input  byteT      specifier,
    input  byteT      operand,
    output regSelT    regRdSel,
    input  byteT      regRdData,
    output decodedT   decoded,
    output byteT      opA,
    output byteT      opB
);

    logic    unary;
    decodedT ctrl;

    assign unary    = (specifier[7:4] == 4'd0);
    assign regRdSel = unary ? specifier[0] : specifier[3];

    always_comb
    begin
        ctrl.op        = opLoad;
        ctrl.regSel    = regRdSel;
        ctrl.writeBack = 1'b1;
        ctrl.active    = 1'b1;
        if (unary)
        begin
            case (specifier[3:1])
                unNot:   ctrl.op = opNot;
                unNeg:   ctrl.op = opNeg;
                unAsl:   ctrl.op = opAsl;
                unAsr:   ctrl.op = opAsr;
                unRol:   ctrl.op = opRol;
                default: ctrl.active = 1'b0;
            endcase
        end
        else
        begin
            case (specifier[7:4])
                nuAdd:   ctrl.op = opAdd;
                nuSub:   ctrl.op = opSub;
                nuAnd:   ctrl.op = opAnd;
                nuOr:    ctrl.op = opOr;
                nuLdb:   ctrl.op = opLoad;
                nuCpb:
                begin
                    ctrl.op        = opSub;
                    ctrl.writeBack = 1'b0;   // Flags only
                end
                default: ctrl.active = 1'b0;
            endcase
        end
        if (!ctrl.active)
            ctrl.writeBack = 1'b0;
    end

    always_ff @(posedge Sysclk)
    begin
        if (!resetbar)
            decoded <= '0;
        else if (decodeEn)
            decoded <= ctrl;
    end

    always_ff @(posedge Sysclk)
    begin
        if (decodeEn)
        begin
            opA <= regRdData;   // Register operand
            opB <= operand;     // Immediate byte
        end
    end

endmodule

`default_nettype wire

//--- hdl/pep9Alu.sv
// 8-bit ALU with result and NZVC registers
// Each operation updates only the flags it defines
// SUB and CPB use opA + ~opB + 1, C is the raw carry out
`timescale 1ns/10ps
`default_nettype none

module pep9Alu import pep9Pkg::*; (
    input  wire logic Sysclk,
    input  wire logic resetbar,
    input  wire logic executeEn,
    input  decodedT   decoded,
    input  byteT      opA,
    input  byteT      opB,
    output byteT      result,
    output flagsT     flags
);

    logic       subMode;
    byteT       addB;
    logic [8:0] sum;
    byteT       res;
    flagsT      nxtFlags;

    // Shared adder for ADD, SUB and CPB
    assign subMode = (decoded.op == opSub);
    assign addB    = subMode ? ~opB : opB;
    assign sum     = {1'b0, opA} + {1'b0, addB} + {8'd0, subMode};

    always_comb
    begin
        nxtFlags = flags;
        res      = result;
        case (decoded.op)
            opAdd, opSub:
            begin
                res        = sum[7:0];
                nxtFlags.v = (opA[7] == addB[7]) && (sum[7] != opA[7]);
                nxtFlags.c = sum[8];
            end
            opLoad: res = opB;
            opAnd:  res = opA & opB;
            opOr:   res = opA | opB;
            opNot:  res = ~opA;
            opNeg:
            begin
                res        = 8'd0 - opA;
                nxtFlags.v = (opA == 8'h80);   // -128 has no positive
            end
            opAsl:
            begin
                res        = {opA[6:0], 1'b0};
                nxtFlags.v = opA[7] ^ opA[6];   // Sign bit changes
                nxtFlags.c = opA[7];
            end
            opAsr:
            begin
                res        = {opA[7], opA[7:1]};
                nxtFlags.c = opA[0];
            end
            opRol:
            begin
                res        = {opA[6:0], flags.c};
                nxtFlags.c = opA[7];
            end
            default: res = result;
        endcase
        // ROL leaves N and Z alone
        if (decoded.op != opRol)
        begin
            nxtFlags.n = res[7];
            nxtFlags.z = (res == 8'd0);
        end
    end

    always_ff @(posedge Sysclk)
    begin
        if (!resetbar)
        begin
            result <= '0;
            flags  <= '0;
        end
        else if (executeEn && decoded.active)
        begin
            result <= res;
            flags  <= nxtFlags;
        end
    end

endmodule

`default_nettype wire

//--- hdl/pep9RegFile.sv
// Low bytes of A and X only
// Combinational read, write on the clock edge
`timescale 1ns/10ps
`default_nettype none

module pep9RegFile import pep9Pkg::*; (
    input  wire logic Sysclk,
    input  wire logic resetbar,
    input  regSelT    rdSel,
    output byteT      rdData,
    input  wire logic wrEn,
    input  regSelT    wrSel,
    input  byteT      wrData
);

    byteT aReg;
    byteT xReg;

    assign rdData = rdSel ? xReg : aReg;

    always_ff @(posedge Sysclk)
    begin
        if (!resetbar)
        begin
            aReg <= '0;
            xReg <= '0;
        end
        else if (wrEn)
        begin
            if (wrSel)
                xReg <= wrData;
            else
                aReg <= wrData;
        end
    end

endmodule

`default_nettype wire

//--- hdl/pep9Top.sv
// Pep/9 subset core, one instruction in flight
// Memory is reached over a four-phase req/ack bus and may stall without limit
// resetPc is the address of the first instruction
`timescale 1ns/10ps
`default_nettype none

module pep9Top import pep9Pkg::*; #(
    parameter addrT resetPc = 16'h0000
) (
    input  wire logic Sysclk,
    input  wire logic resetbar,
    output logic      memReq,
    output addrT      memAddr,
    input  wire logic memAck,
    input  byteT      memData,
    output byteT      result,
    output flagsT     flags,
    output logic      retire
);

    logic    fetchStart, fetchDone;
    logic    decodeEn, executeEn, storeEn;
    byteT    specifier, operand;
    regSelT  regRdSel;
    byteT    regRdData;
    decodedT decoded;
    byteT    opA, opB;

    pep9Sequencer uSequencer (.Sysclk, .resetbar, .fetchDone, .fetchStart,
                              .decodeEn, .executeEn, .storeEn, .retire);

    pep9Fetch #(.resetPc(resetPc)) uFetch (.Sysclk, .resetbar, .fetchStart,
                                           .memReq, .memAddr, .memAck, .memData,
                                           .specifier, .operand, .fetchDone);

    pep9Decode uDecode (.Sysclk, .resetbar, .decodeEn, .specifier, .operand,
                        .regRdSel, .regRdData, .decoded, .opA, .opB);

    pep9Alu uAlu (.Sysclk, .resetbar, .executeEn, .decoded, .opA, .opB,
                  .result, .flags);

    pep9RegFile uRegFile (.Sysclk, .resetbar, .rdSel(regRdSel), .rdData(regRdData),
                          .wrEn(storeEn && decoded.writeBack),
                          .wrSel(decoded.regSel), .wrData(result));

endmodule

`default_nettype wire

//--- verification/pep9Tb_sva.sv
// Four-phase bus and stage timing checks, bound into pep9Top
// Reaches the sequencer state through the uSequencer instance
`timescale 1ns/10ps
`default_nettype none

module pep9Tb_sva import pep9Pkg::*; (
    input wire logic Sysclk,
    input wire logic resetbar,
    input wire logic memReq,
    input wire logic memAck,
    input addrT      memAddr,
    input wire logic fetchStart,
    input wire logic fetchDone,
    input wire logic decodeEn,
    input wire logic executeEn,
    input wire logic storeEn,
    input wire logic retire,
    input cpuStateT  state
);

    int svaErrors = 0;

    aReqLowInReset: assert property (@(posedge Sysclk) !resetbar |=> !memReq)
        else
        begin
            svaErrors++;
            $error("memReq is high after reset");
        end

    // Request and address held until ack
    aReqHeld: assert property (@(posedge Sysclk) disable iff (!resetbar)
                               memReq && !memAck |=> memReq && $stable(memAddr))
        else
        begin
            svaErrors++;
            $error("memReq or memAddr changed before memAck");
        end

    aReqDrop: assert property (@(posedge Sysclk) disable iff (!resetbar)
                               memReq && memAck |=> !memReq)
        else
        begin
            svaErrors++;
            $error("memReq still high after memAck");
        end

    aNoEarlyReq: assert property (@(posedge Sysclk) disable iff (!resetbar)
                                  !memReq && memAck |=> !memReq)
        else
        begin
            svaErrors++;
            $error("new memReq raised while memAck is high");
        end

    aRetireDelay: assert property (@(posedge Sysclk) disable iff (!resetbar)
                                   fetchDone |-> ##3 retire)
        else
        begin
            svaErrors++;
            $error("retire did not follow fetchDone after 3 cycles");
        end

    aOneHot: assert property (@(posedge Sysclk) disable iff (!resetbar)
                              $onehot0({fetchStart, decodeEn, executeEn, storeEn}))
        else
        begin
            svaErrors++;
            $error("stage enables are not one-hot");
        end

    // Decode, execute, store, one cycle each, then back to fetch
    aStageOrder: assert property (@(posedge Sysclk) disable iff (!resetbar)
                                  decodeEn |-> state == stDecode
                                  ##1 executeEn && state == stExecute
                                  ##1 storeEn && retire && state == stStore
                                  ##1 !storeEn && state == stFetch)
        else
        begin
            svaErrors++;
            $error("stage enables out of order or longer than one cycle");
        end

endmodule

bind pep9Top pep9Tb_sva uSva (
    .Sysclk(Sysclk),
    .resetbar(resetbar),
    .memReq(memReq),
    .memAck(memAck),
    .memAddr(memAddr),
    .fetchStart(fetchStart),
    .fetchDone(fetchDone),
    .decodeEn(decodeEn),
    .executeEn(executeEn),
    .storeEn(storeEn),
    .retire(retire),
    .state(uSequencer.state)
);

`default_nettype wire

//--- verification/pep9Tb.sv
// Directed then random program for pep9Top, served by a four-phase memory model
// Program must fit in the 256 bytes above resetPc
`timescale 1ns/10ps
`default_nettype none

module pep9Tb import pep9Pkg::*; ();

    localparam addrT resetPc = 16'h0100;
    localparam int   nDir    = 28;
    localparam int   nRand   = 40;
    localparam int   nInstr  = nDir + nRand;

    logic   Sysclk;
    logic   resetbar;
    logic   memReq;
    addrT   memAddr;
    logic   memAck;
    byteT   memData;
    byteT   result;
    flagsT  flags;
    logic   retire;

    byteT   mem [0:255];
    byteT   expRes [nInstr];
    flagsT  expFlags [nInstr];
    addrT   expPc [nInstr];    // PC after each instruction
    byteT   mA;
    byteT   mX;
    byteT   mRes;
    flagsT  mF;
    byteT   nowRes;
    flagsT  nowFlags;
    addrT   nowPc;
    addrT   expAddr;
    int     retCnt;
    int     errors = 0;
    integer seed;

    // {specifier, operand}, operand unused for unary
    logic [15:0] directed [nDir] = '{
        16'hD07F, 16'h6001, 16'hD800, 16'h7801,   // 7F + 1 and 00 - 1
        16'h6080, 16'h800F, 16'h9801, 16'hD081,   // Carry out then AND and OR
        16'hB081, 16'h0600, 16'h0E00, 16'h0E00,   // CPB keeps A, ROL takes old C
        16'h0D00, 16'h0B00, 16'h0900, 16'hD880,
        16'h0900, 16'h0A00, 16'h0C00, 16'h0800,   // NEG of 80 overflows
        16'h0F00, 16'h0000, 16'h2055, 16'h0200,   // Unknown specifiers
        16'hB8FF, 16'h0700, 16'h0600, 16'h6A7F    // Read A and X back
    };

    pep9Top #(.resetPc(resetPc)) DUT (.*);

    initial
    begin
        Sysclk = 1'b0;
        forever #10 Sysclk = ~Sysclk;
    end

    // Reference model, one instruction at a time
    task automatic applyInstr(input byteT spec, input byteT oper);
        logic       unary;
        logic       sel;
        logic       known;
        logic       arith;
        logic       wb;
        byteT       a;
        byteT       res;
        logic [8:0] sum;
        int         sres;
        unary = (spec[7:4] == 4'h0);
        sel   = unary ? spec[0] : spec[3];
        a     = sel ? mX : mA;
        res   = a;
        known = 1'b1;
        arith = 1'b0;
        wb    = 1'b1;
        sum   = '0;
        sres  = 0;
        if (unary)
        begin
            case (spec[3:1])
                3'd3: res = ~a;
                3'd4:
                begin
                    res  = -a;
                    mF.v = a[7] && res[7];   // Negative stays negative
                end
                3'd5:
                begin
                    res  = a << 1;
                    mF.v = (res[7] != a[7]);
                    mF.c = a[7];
                end
                3'd6:
                begin
                    res  = {a[7], a[7:1]};
                    mF.c = a[0];
                end
                3'd7:
                begin
                    res  = {a[6:0], mF.c};
                    mF.c = a[7];
                end
                default: known = 1'b0;
            endcase
        end
        else
        begin
            case (spec[7:4])
                4'h6:
                begin
                    arith = 1'b1;
                    sum   = {1'b0, a} + {1'b0, oper};
                    sres  = $signed(a) + $signed(oper);
                end
                4'h7, 4'hB:
                begin
                    arith = 1'b1;
                    wb    = (spec[7:4] == 4'h7);   // CPB sets flags only
                    sum   = {1'b0, a} + {1'b0, ~oper} + 9'd1;
                    sres  = $signed(a) - $signed(oper);
                end
                4'h8: res = a & oper;
                4'h9: res = a | oper;
                4'hD: res = oper;
                default: known = 1'b0;
            endcase
        end
        if (arith)
        begin
            res  = sum[7:0];
            mF.v = (sres > 127) || (sres < -128);
            mF.c = sum[8];
        end
        if (known)
        begin
            if (!(unary && spec[3:1] == 3'd7))   // ROL keeps N and Z
            begin
                mF.n = res[7];
                mF.z = (res == 8'h00);
            end
            mRes = res;
            if (wb && sel)
                mX = res;
            else if (wb)
                mA = res;
        end
    endtask

    task automatic reportMismatch(input string name, input logic [15:0] got,
                                  input logic [15:0] exp);
        errors++;
        $display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
    endtask

    // Four-phase memory, answers after 0 to 3 cycles
    initial
    begin
        int delay;
        memAck  = 1'b0;
        memData = 8'h00;
        forever
        begin
            @(posedge Sysclk);
            if (memReq && !memAck)
            begin
                delay = {$random(seed)} % 4;
                repeat (delay) @(posedge Sysclk);
                memData <= mem[memAddr - resetPc];
                memAck  <= 1'b1;
                do
                    @(posedge Sysclk);
                while (memReq);
                memAck <= 1'b0;
            end
        end
    end

    always @(posedge Sysclk)
    begin
        if (!resetbar)
        begin
            retCnt  <= 0;
            expAddr <= resetPc;
        end
        else
        begin
            if (retire)
                retCnt <= retCnt + 1;
            if (memReq && memAck)
                expAddr <= expAddr + 16'd1;   // One per byte read
        end
    end

    assign nowRes   = expRes[retCnt];
    assign nowFlags = expFlags[retCnt];
    assign nowPc    = expPc[retCnt];

    aResult: assert property (@(posedge Sysclk) disable iff (!resetbar)
                              retire |-> result == nowRes)
        else reportMismatch("result", $sampled(result), $sampled(nowRes));

    aFlags: assert property (@(posedge Sysclk) disable iff (!resetbar)
                             retire |-> flags == nowFlags)
        else reportMismatch("flags", $sampled(flags), $sampled(nowFlags));

    aPc: assert property (@(posedge Sysclk) disable iff (!resetbar)
                          retire |-> memAddr == nowPc)
        else reportMismatch("memAddr", $sampled(memAddr), $sampled(nowPc));

    aAddr: assert property (@(posedge Sysclk) disable iff (!resetbar)
                            memReq |-> memAddr == expAddr)
        else reportMismatch("memAddr", $sampled(memAddr), $sampled(expAddr));

    initial
    begin
        byteT        spec;
        byteT        oper;
        logic [31:0] rnd;
        int          pos;
        byteT        keptOps [11] = '{8'h06, 8'h08, 8'h0A, 8'h0C, 8'h0E,
                                      8'h60, 8'h70, 8'h80, 8'h90, 8'hB0, 8'hD0};
        seed     = 10;
        resetbar = 1'b0;
        for (int i = 0; i < 256; i++)
            mem[i] = byteT'(i * 37 + 5);
        mA   = '0;
        mX   = '0;
        mF   = '0;
        mRes = '0;
        pos  = 0;
        for (int i = 0; i < nInstr; i++)
        begin
            if (i < nDir)
                {spec, oper} = directed[i];
            else
            begin
                rnd  = $random(seed);
                spec = keptOps[rnd[7:0] % 11];
                if (spec[7:4] == 4'h0)
                    spec[0] = rnd[8];
                else
                    spec[3:0] = rnd[11:8];   // Register bit and ignored mode bits
                oper = rnd[23:16];
            end
            mem[pos] = spec;
            pos++;
            if (spec[7:4] != 4'h0)
            begin
                mem[pos] = oper;
                pos++;
            end
            applyInstr(spec, oper);
            expRes[i]   = mRes;
            expFlags[i] = mF;
            expPc[i]    = resetPc + addrT'(pos);
        end
        repeat (2) @(posedge Sysclk);
        resetbar <= 1'b1;
        wait (retCnt == nInstr);
        repeat (2) @(posedge Sysclk);
        $display("Errors: %0d value, %0d bus or timing", errors, DUT.uSva.svaErrors);
        if (errors == 0 && DUT.uSva.svaErrors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

    // Watchdog
    initial
    begin
        repeat (200 * nInstr) @(posedge Sysclk);
        $display("Timeout: only %0d of %0d instructions retired", retCnt, nInstr);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
hdl/pep9Pkg.sv
hdl/pep9Sequencer.sv
hdl/pep9Fetch.sv
hdl/pep9Decode.sv
hdl/pep9Alu.sv
hdl/pep9RegFile.sv
hdl/pep9Top.sv
verification/pep9Tb_sva.sv
verification/pep9Tb.sv
